// ==== hw/dbg_ring_defs.svh ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// debug ring sizing and addressing.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef DBG_RING_DEFS_SVH
`define DBG_RING_DEFS_SVH

`define DBG_FLIT_W    16  // flit data bits.
`define DBG_ADDR_W    4   // destination in low bits of flit 0.
`define DBG_NUM_NODES 4   // router i answers to address i+1.
`define DBG_HOST_ADDR 0   // host side of the chain.

`endif

// ==== hw/dbg_ring_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// debug ring shared types.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "dbg_ring_defs.svh"

package dbg_ring_pkg;

  typedef logic [`DBG_FLIT_W-1:0] flit_data_t;  // payload of one flit.
  typedef logic [`DBG_ADDR_W-1:0] node_addr_t;  // node or host address.

  // gateway lock, which source owns the output.
  typedef enum logic [1:0] {no_worm, worm_ring, worm_local, worm_ext} worm_state_t;

  // worm framing position.
  typedef enum logic [1:0] {hdr_dest, hdr_src, payload} hdr_state_t;

endpackage

// ==== hw/dbg_flit_buffer.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// two-entry flit skid buffer, registered
// output, one flit per cycle.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module dbg_flit_buffer (
  input  logic                     clk,
  input  logic                     rst,
  input  dbg_ring_pkg::flit_data_t in_data,
  input  logic                     in_last,
  input  logic                     in_valid,
  output logic                     in_ready,
  output dbg_ring_pkg::flit_data_t out_data,
  output logic                     out_last,
  output logic                     out_valid,
  input  logic                     out_ready
);

  dbg_ring_pkg::flit_data_t skid_data;  // overflow entry.
  logic                     skid_last;
  logic                     skid_valid;
  logic                     load_out;   // output register free this cycle.
  logic                     load_skid;  // accepted flit has nowhere else to go.

  assign in_ready  = ~skid_valid;  // registered, breaks the ready chain.
  assign load_out  = out_ready | ~out_valid;
  assign load_skid = in_valid & in_ready & ~load_out;

  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // occupancy
  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid  <= 1'b0;
      skid_valid <= 1'b0;
    end else if (load_out) begin
      out_valid  <= skid_valid | in_valid;  // skid drains first.
      skid_valid <= 1'b0;
    end else if (load_skid) begin
      skid_valid <= 1'b1;
    end
  end

  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // flit storage
  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk) begin
    if (load_out) begin
      if (skid_valid) begin
        out_data <= skid_data;  // oldest flit out first.
        out_last <= skid_last;
      end else begin
        out_data <= in_data;
        out_last <= in_last;
      end
    end
    if (load_skid) begin
      skid_data <= in_data;  // output stalled, park it.
      skid_last <= in_last;
    end
  end

endmodule

// ==== hw/dbg_gateway_mux.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// wormhole gateway, ring before local
// before ext, grant held for a whole worm.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module dbg_gateway_mux (
  input  logic                     clk,
  input  logic                     rst,
  input  dbg_ring_pkg::flit_data_t ring_data,
  input  logic                     ring_last,
  input  logic                     ring_valid,
  output logic                     ring_ready,
  input  dbg_ring_pkg::flit_data_t local_data,
  input  logic                     local_last,
  input  logic                     local_valid,
  output logic                     local_ready,
  input  dbg_ring_pkg::flit_data_t ext_data,
  input  logic                     ext_last,
  input  logic                     ext_valid,
  output logic                     ext_ready,
  output dbg_ring_pkg::flit_data_t out_data,
  output logic                     out_last,
  output logic                     out_valid,
  input  logic                     out_ready
);

  dbg_ring_pkg::worm_state_t state;  // locked source, no_worm when idle.
  dbg_ring_pkg::worm_state_t grant;  // source routed this cycle.

  // arbitration, only when no worm holds the output.
  always_comb begin
    grant = state;
    if (state == dbg_ring_pkg::no_worm) begin
      if (ring_valid) begin
        grant = dbg_ring_pkg::worm_ring;  // through traffic wins.
      end else if (local_valid) begin
        grant = dbg_ring_pkg::worm_local;
      end else if (ext_valid) begin
        grant = dbg_ring_pkg::worm_ext;
      end
    end
  end

  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // datapath select
  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    out_data    = ring_data;
    out_last    = ring_last;
    out_valid   = 1'b0;
    ring_ready  = 1'b0;  // losers see no ready.
    local_ready = 1'b0;
    ext_ready   = 1'b0;
    case (grant)
      dbg_ring_pkg::worm_ring: begin
        out_valid  = ring_valid;
        ring_ready = out_ready;
      end
      dbg_ring_pkg::worm_local: begin
        out_data    = local_data;
        out_last    = local_last;
        out_valid   = local_valid;
        local_ready = out_ready;
      end
      dbg_ring_pkg::worm_ext: begin
        out_data  = ext_data;
        out_last  = ext_last;
        out_valid = ext_valid;
        ext_ready = out_ready;
      end
      default: out_valid = 1'b0;  // idle, nothing pending.
    endcase
  end

  // lock on a non-last transfer, release on the last one.
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= dbg_ring_pkg::no_worm;
    end else if (out_valid && out_ready) begin
      state <= out_last ? dbg_ring_pkg::no_worm : grant;
    end
  end

endmodule

// ==== hw/dbg_ring_router.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ring station: delivers its own worms,
// merges the rest with injected traffic.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "dbg_ring_defs.svh"

module dbg_ring_router #(
  parameter dbg_ring_pkg::node_addr_t node_addr = 1
) (
  input  logic                     clk,
  input  logic                     rst,
  input  dbg_ring_pkg::flit_data_t ring_in_data,
  input  logic                     ring_in_last,
  input  logic                     ring_in_valid,
  output logic                     ring_in_ready,
  output dbg_ring_pkg::flit_data_t ring_out_data,
  output logic                     ring_out_last,
  output logic                     ring_out_valid,
  input  logic                     ring_out_ready,
  input  dbg_ring_pkg::flit_data_t local_in_data,
  input  logic                     local_in_last,
  input  logic                     local_in_valid,
  output logic                     local_in_ready,
  input  dbg_ring_pkg::flit_data_t ext_in_data,
  input  logic                     ext_in_last,
  input  logic                     ext_in_valid,
  output logic                     ext_in_ready,
  output dbg_ring_pkg::flit_data_t local_out_data,
  output logic                     local_out_last,
  output logic                     local_out_valid,
  input  logic                     local_out_ready
);

  logic                     in_worm;      // past the first ring flit.
  logic                     to_local_q;   // routing decision of this worm.
  logic                     to_local;     // decision applied this cycle.
  logic                     fwd_ready;    // gateway ready for ring traffic.
  dbg_ring_pkg::flit_data_t mux_data;
  logic                     mux_last;
  logic                     mux_valid;
  logic                     mux_ready;

  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // destination filter
  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign to_local = in_worm ? to_local_q : (ring_in_data[`DBG_ADDR_W-1:0] == node_addr);

  assign local_out_data  = ring_in_data;  // delivered with the header intact.
  assign local_out_last  = ring_in_last;
  assign local_out_valid = ring_in_valid & to_local;
  assign ring_in_ready   = to_local ? local_out_ready : fwd_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      in_worm    <= 1'b0;
      to_local_q <= 1'b0;
    end else if (ring_in_valid && ring_in_ready) begin
      in_worm    <= ~ring_in_last;
      to_local_q <= to_local;  // held until the last flit.
    end
  end

  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // merge and output stage
  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  dbg_gateway_mux u_mux (
    .clk(clk), .rst(rst),
    .ring_data(ring_in_data), .ring_last(ring_in_last),
    .ring_valid(ring_in_valid & ~to_local), .ring_ready(fwd_ready),
    .local_data(local_in_data), .local_last(local_in_last),
    .local_valid(local_in_valid), .local_ready(local_in_ready),
    .ext_data(ext_in_data), .ext_last(ext_in_last),
    .ext_valid(ext_in_valid), .ext_ready(ext_in_ready),
    .out_data(mux_data), .out_last(mux_last),
    .out_valid(mux_valid), .out_ready(mux_ready)
  );

  dbg_flit_buffer u_buf (
    .clk(clk), .rst(rst),
    .in_data(mux_data), .in_last(mux_last),
    .in_valid(mux_valid), .in_ready(mux_ready),
    .out_data(ring_out_data), .out_last(ring_out_last),
    .out_valid(ring_out_valid), .out_ready(ring_out_ready)
  );

endmodule

// ==== hw/dbg_host_ingress.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// host ingress: prefixes destination and
// source flits to each host request.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "dbg_ring_defs.svh"

module dbg_host_ingress (
  input  logic                     clk,
  input  logic                     rst,
  input  dbg_ring_pkg::flit_data_t host_in_data,
  input  dbg_ring_pkg::node_addr_t host_in_dest,
  input  logic                     host_in_last,
  input  logic                     host_in_valid,
  output logic                     host_in_ready,
  output dbg_ring_pkg::flit_data_t out_data,
  output logic                     out_last,
  output logic                     out_valid,
  input  logic                     out_ready
);

  dbg_ring_pkg::hdr_state_t state;
  dbg_ring_pkg::hdr_state_t state_nxt;

  always_comb begin
    state_nxt     = state;
    out_data      = host_in_data;
    out_last      = 1'b0;  // headers never end a worm.
    out_valid     = host_in_valid;
    host_in_ready = 1'b0;  // word held while headers go out.
    case (state)
      dbg_ring_pkg::hdr_dest: begin
        out_data = dbg_ring_pkg::flit_data_t'(host_in_dest);  // first word pending.
        if (host_in_valid && out_ready) begin
          state_nxt = dbg_ring_pkg::hdr_src;
        end
      end
      dbg_ring_pkg::hdr_src: begin
        out_data  = dbg_ring_pkg::flit_data_t'(`DBG_HOST_ADDR);
        out_valid = 1'b1;
        if (out_ready) begin
          state_nxt = dbg_ring_pkg::payload;
        end
      end
      default: begin
        out_last      = host_in_last;  // payload straight through.
        host_in_ready = out_ready;
        if (host_in_valid && out_ready && host_in_last) begin
          state_nxt = dbg_ring_pkg::hdr_dest;
        end
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= dbg_ring_pkg::hdr_dest;
    end else begin
      state <= state_nxt;
    end
  end

endmodule

// ==== hw/dbg_host_egress.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// host egress: strips the worm header,
// drops and counts misaddressed worms.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "dbg_ring_defs.svh"

module dbg_host_egress (
  input  logic                     clk,
  input  logic                     rst,
  input  dbg_ring_pkg::flit_data_t in_data,
  input  logic                     in_last,
  input  logic                     in_valid,
  output logic                     in_ready,
  output dbg_ring_pkg::flit_data_t host_out_data,
  output dbg_ring_pkg::node_addr_t host_out_src,
  output logic                     host_out_last,
  output logic                     host_out_valid,
  input  logic                     host_out_ready,
  output logic [7:0]               drop_count
);

  dbg_ring_pkg::hdr_state_t state;
  dbg_ring_pkg::node_addr_t dest_q;    // captured from flit 0.
  dbg_ring_pkg::node_addr_t src_q;     // captured from flit 1.
  logic                     for_host;  // current worm is ours.
  logic                     deliver;   // payload flit bound for the host.
  logic                     xfer;

  assign for_host = (state == dbg_ring_pkg::hdr_dest) ?
                    (in_data[`DBG_ADDR_W-1:0] == dbg_ring_pkg::node_addr_t'(`DBG_HOST_ADDR)) :
                    (dest_q == dbg_ring_pkg::node_addr_t'(`DBG_HOST_ADDR));
  assign deliver  = (state == dbg_ring_pkg::payload) & for_host;

  assign host_out_data  = in_data;
  assign host_out_src   = src_q;
  assign host_out_last  = in_last;
  assign host_out_valid = in_valid & deliver;
  assign in_ready       = deliver ? host_out_ready : 1'b1;  // headers and drops sink freely.
  assign xfer           = in_valid & in_ready;

  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // framing and drop counter
  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= dbg_ring_pkg::hdr_dest;
      drop_count <= 8'd0;
    end else if (xfer) begin
      if (in_last) begin
        state <= dbg_ring_pkg::hdr_dest;
        if (!for_host) begin
          drop_count <= drop_count + 8'd1;  // once per dropped worm.
        end
      end else if (state == dbg_ring_pkg::hdr_dest) begin
        state <= dbg_ring_pkg::hdr_src;
      end else if (state == dbg_ring_pkg::hdr_src) begin
        state <= dbg_ring_pkg::payload;
      end
    end
  end

  // header capture.
  always_ff @(posedge clk) begin
    if (xfer && state == dbg_ring_pkg::hdr_dest) begin
      dest_q <= in_data[`DBG_ADDR_W-1:0];
    end
    if (xfer && state == dbg_ring_pkg::hdr_src) begin
      src_q <= in_data[`DBG_ADDR_W-1:0];
    end
  end

endmodule

// ==== hw/dbg_ring.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// debug ring segment: host ingress, chain
// of routers, host egress.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "dbg_ring_defs.svh"

module dbg_ring (
  input  logic                                  clk,
  input  logic                                  rst,
  input  dbg_ring_pkg::flit_data_t              host_in_data,
  input  dbg_ring_pkg::node_addr_t              host_in_dest,
  input  logic                                  host_in_last,
  input  logic                                  host_in_valid,
  output logic                                  host_in_ready,
  output dbg_ring_pkg::flit_data_t              host_out_data,
  output dbg_ring_pkg::node_addr_t              host_out_src,
  output logic                                  host_out_last,
  output logic                                  host_out_valid,
  input  logic                                  host_out_ready,
  output logic [7:0]                            drop_count,
  input  logic [`DBG_NUM_NODES*`DBG_FLIT_W-1:0] local_in_data,
  input  logic [`DBG_NUM_NODES-1:0]             local_in_last,
  input  logic [`DBG_NUM_NODES-1:0]             local_in_valid,
  output logic [`DBG_NUM_NODES-1:0]             local_in_ready,
  input  logic [`DBG_NUM_NODES*`DBG_FLIT_W-1:0] ext_in_data,
  input  logic [`DBG_NUM_NODES-1:0]             ext_in_last,
  input  logic [`DBG_NUM_NODES-1:0]             ext_in_valid,
  output logic [`DBG_NUM_NODES-1:0]             ext_in_ready,
  output logic [`DBG_NUM_NODES*`DBG_FLIT_W-1:0] local_out_data,
  output logic [`DBG_NUM_NODES-1:0]             local_out_last,
  output logic [`DBG_NUM_NODES-1:0]             local_out_valid,
  input  logic [`DBG_NUM_NODES-1:0]             local_out_ready
);

  // chain links, index i feeds router i, the last one feeds egress.
  dbg_ring_pkg::flit_data_t      ring_data [`DBG_NUM_NODES+1];
  logic [`DBG_NUM_NODES:0]       ring_last;
  logic [`DBG_NUM_NODES:0]       ring_valid;
  logic [`DBG_NUM_NODES:0]       ring_ready;

  dbg_host_ingress u_ingress (
    .clk(clk), .rst(rst),
    .host_in_data(host_in_data), .host_in_dest(host_in_dest),
    .host_in_last(host_in_last), .host_in_valid(host_in_valid),
    .host_in_ready(host_in_ready),
    .out_data(ring_data[0]), .out_last(ring_last[0]),
    .out_valid(ring_valid[0]), .out_ready(ring_ready[0])
  );

  for (genvar i = 0; i < `DBG_NUM_NODES; i++) begin : g_node
    dbg_ring_router #(
      .node_addr(dbg_ring_pkg::node_addr_t'(i + 1))  // host owns address 0.
    ) u_router (
      .clk(clk), .rst(rst),
      .ring_in_data(ring_data[i]), .ring_in_last(ring_last[i]),
      .ring_in_valid(ring_valid[i]), .ring_in_ready(ring_ready[i]),
      .ring_out_data(ring_data[i+1]), .ring_out_last(ring_last[i+1]),
      .ring_out_valid(ring_valid[i+1]), .ring_out_ready(ring_ready[i+1]),
      .local_in_data(local_in_data[i*`DBG_FLIT_W +: `DBG_FLIT_W]),
      .local_in_last(local_in_last[i]), .local_in_valid(local_in_valid[i]),
      .local_in_ready(local_in_ready[i]),
      .ext_in_data(ext_in_data[i*`DBG_FLIT_W +: `DBG_FLIT_W]),
      .ext_in_last(ext_in_last[i]), .ext_in_valid(ext_in_valid[i]),
      .ext_in_ready(ext_in_ready[i]),
      .local_out_data(local_out_data[i*`DBG_FLIT_W +: `DBG_FLIT_W]),
      .local_out_last(local_out_last[i]), .local_out_valid(local_out_valid[i]),
      .local_out_ready(local_out_ready[i])
    );
  end

  dbg_host_egress u_egress (
    .clk(clk), .rst(rst),
    .in_data(ring_data[`DBG_NUM_NODES]), .in_last(ring_last[`DBG_NUM_NODES]),
    .in_valid(ring_valid[`DBG_NUM_NODES]), .in_ready(ring_ready[`DBG_NUM_NODES]),
    .host_out_data(host_out_data), .host_out_src(host_out_src),
    .host_out_last(host_out_last), .host_out_valid(host_out_valid),
    .host_out_ready(host_out_ready), .drop_count(drop_count)
  );

endmodule

// ==== tb/dbg_ring_tb.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// debug ring testbench with endpoint models,
// a per-receiver scoreboard and a table of worms.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "dbg_ring_defs.svh"

module dbg_ring_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int nn       = `DBG_NUM_NODES;
  localparam int fw       = `DBG_FLIT_W;
  localparam int max_wait = 3000;  // cycles per wait loop.
  localparam int tbl_n    = 12;
  localparam int max_len  = 8;

  logic                 clk;
  logic                 rst;
  logic [fw-1:0]        host_in_data;
  logic [3:0]           host_in_dest;
  logic                 host_in_last, host_in_valid, host_in_ready;
  logic [fw-1:0]        host_out_data;
  logic [3:0]           host_out_src;
  logic                 host_out_last, host_out_valid, host_out_ready;
  logic [7:0]           drop_count;
  logic [nn*fw-1:0]     local_in_data, ext_in_data, local_out_data;
  logic [nn-1:0]        local_in_last, local_in_valid, local_in_ready;
  logic [nn-1:0]        ext_in_last, ext_in_valid, ext_in_ready;
  logic [nn-1:0]        local_out_last, local_out_valid, local_out_ready;

  // kind is 0 for host, 1 for local and 2 for ext.
  // node is 1-based and 0 for the host.
  int tbl_kind [tbl_n] = '{0, 0, 1, 2, 1, 2, 0, 1, 2, 0, 1, 2};
  int tbl_node [tbl_n] = '{0, 0, 1, 3, 2, 4, 0, 2, 2, 0, 3, 1};
  int tbl_dest [tbl_n] = '{1, 4, 0, 4, 7, 2, 3, 4, 0, 2, 0, 4};
  int tbl_len  [tbl_n] = '{3, 5, 4, 2, 3, 2, 6, 5, 4, 8, 6, 7};
  int tbl_thr  [tbl_n] = '{0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 1, 1};
  int tbl_wait [tbl_n] = '{1, 1, 1, 1, 1, 1, 0, 0, 1, 1, 1, 1};  // 0 overlaps next.

  logic [fw-1:0] pay [tbl_n][max_len];
  logic [20:0]   exp_q [nn+1][$];  // {last, src, data} with queue 0 for the host.
  logic [15:0]   lfsr_state = 16'd71;
  int            exp_drops;
  int            active_srcs;
  logic          throttle;

  dbg_ring uut (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // helpers
  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  function automatic logic lfsr_bit();
    logic b;
    b          = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (b) lfsr_state = lfsr_state ^ 16'hB400;  // galois taps 16,14,13,11.
    return b;
  endfunction

  function automatic logic [fw-1:0] lfsr_word();
    logic [fw-1:0] w;
    for (int k = 0; k < fw; k++) w[k] = lfsr_bit();
    return w;
  endfunction

  task automatic fail_run(string why);
    $display("%s", why);
    $display("=== FAIL ===");
    $fatal(1);
  endtask

  task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) fail_run($sformatf("ERROR %s got %h expected %h", name, got, exp));
  endtask

  // source i drives one worm with one flit per accepted cycle.
  task automatic send_worm(int i);
    int            kind, n, nflits, t;
    logic [fw-1:0] d;
    logic          l, rdy;
    kind   = tbl_kind[i];
    n      = tbl_node[i];
    nflits = (kind == 0) ? tbl_len[i] : tbl_len[i] + 2;
    for (int k = 0; k < nflits; k++) begin
      l = (k == nflits - 1);
      if (kind == 0) begin
        host_in_data  = pay[i][k];
        host_in_dest  = tbl_dest[i];
        host_in_last  = l;
        host_in_valid = 1'b1;
      end else begin
        d = (k == 0) ? fw'(tbl_dest[i]) : (k == 1) ? fw'(n) : pay[i][k-2];  // own header.
        if (kind == 1) begin
          local_in_data[(n-1)*fw +: fw] = d;
          local_in_last[n-1]            = l;
          local_in_valid[n-1]           = 1'b1;
        end else begin
          ext_in_data[(n-1)*fw +: fw] = d;
          ext_in_last[n-1]            = l;
          ext_in_valid[n-1]           = 1'b1;
        end
      end
      t = 0;
      do begin
        @(negedge clk);
        rdy = (kind == 0) ? host_in_ready : (kind == 1) ? local_in_ready[n-1] : ext_in_ready[n-1];
        t++;
        if (t > max_wait) fail_run("source never saw ready, flit stuck");
      end while (!rdy);
      @(posedge clk);
      #10;
    end
    if (kind == 0) host_in_valid = 1'b0;
    else if (kind == 1) local_in_valid[n-1] = 1'b0;
    else ext_in_valid[n-1] = 1'b0;
    active_srcs--;
  endtask

  // fill payload and queue the expected flits from the routing rules.
  task automatic plan_worm(int i);
    int d, srcpos, rx;
    d      = tbl_dest[i];
    srcpos = tbl_node[i];  // injection sits after router srcpos.
    for (int k = 0; k < tbl_len[i]; k++) pay[i][k] = lfsr_word();
    if (d >= 1 && d <= nn && d > srcpos) begin
      exp_q[d].push_back({1'b0, 4'd0, fw'(d)});
      exp_q[d].push_back({1'b0, 4'd0, fw'(srcpos)});
      for (int k = 0; k < tbl_len[i]; k++)
        exp_q[d].push_back({k == tbl_len[i] - 1, 4'd0, pay[i][k]});
    end else if (d == `DBG_HOST_ADDR) begin
      rx = 0;
      for (int k = 0; k < tbl_len[i]; k++)
        exp_q[rx].push_back({k == tbl_len[i] - 1, 4'(srcpos), pay[i][k]});
    end else begin
      exp_drops++;  // falls off the end of the chain.
    end
  endtask

  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // sinks and scoreboard
  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin
    forever begin
      @(posedge clk);
      #10;
      for (int d = 0; d < nn; d++) local_out_ready[d] = throttle ? lfsr_bit() : 1'b1;
      host_out_ready = throttle ? lfsr_bit() : 1'b1;
    end
  end

  initial begin
    logic [20:0] e;
    forever begin
      @(negedge clk);  // transfer seen before the edge that takes it.
      if (!rst && host_out_valid && host_out_ready) begin
        if (exp_q[0].size() == 0) fail_run("host_out delivered a flit nobody sent to the host");
        e = exp_q[0].pop_front();
        check_value("host_out_data", host_out_data, e[15:0]);
        check_value("host_out_src", host_out_src, e[19:16]);
        check_value("host_out_last", host_out_last, e[20]);
      end
      for (int d = 0; d < nn; d++) begin
        if (!rst && local_out_valid[d] && local_out_ready[d]) begin
          if (exp_q[d+1].size() == 0) fail_run("local_out delivered an unexpected flit");
          e = exp_q[d+1].pop_front();
          check_value($sformatf("local_out_data[%0d]", d), local_out_data[d*fw +: fw], e[15:0]);
          check_value($sformatf("local_out_last[%0d]", d), local_out_last[d], e[20]);
        end
      end
    end
  end

  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // main sequence
  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin
    int  t;
    bit  busy;
    rst = 1'b1;
    host_in_data = '0;
    host_in_dest = '0;
    host_in_last = 1'b0;
    host_in_valid = 1'b0;
    host_out_ready = 1'b1;
    local_in_data = '0;
    local_in_last = '0;
    local_in_valid = '0;
    ext_in_data = '0;
    ext_in_last = '0;
    ext_in_valid = '0;
    local_out_ready = '1;
    throttle = 1'b0;
    exp_drops = 0;
    active_srcs = 0;
    repeat (2) @(posedge clk);
    #10;
    // reset values.
    check_value("host_out_valid", host_out_valid, 0);
    check_value("local_out_valid", local_out_valid, 0);
    check_value("drop_count", drop_count, 0);
    check_value("host_in_ready", host_in_ready, 0);
    check_value("local_in_ready", local_in_ready, 0);
    check_value("ext_in_ready", ext_in_ready, 0);
    rst = 1'b0;
    @(posedge clk);
    #10;
    for (int i = 0; i < tbl_n; i++) begin
      throttle = tbl_thr[i];
      plan_worm(i);
      active_srcs++;
      fork
        automatic int idx = i;
        send_worm(idx);
      join_none
      if (tbl_wait[i]) begin
        t = 0;
        do begin
          @(posedge clk);
          #10;
          busy = (active_srcs != 0) || (drop_count < exp_drops);
          for (int q = 0; q <= nn; q++) if (exp_q[q].size() != 0) busy = 1'b1;
          t++;
          if (t > max_wait) fail_run($sformatf("entry %0d never drained from the chain", i));
        end while (busy);
        check_value("drop_count", drop_count, exp_drops);
      end
    end
    repeat (5) @(posedge clk);
    check_value("drop_count", drop_count, exp_drops);
    $display("=== PASS ===");
    $finish;
  end

endmodule

// ==== dbg_ring.f ====
+incdir+hw
hw/dbg_ring_pkg.sv
hw/dbg_flit_buffer.sv
hw/dbg_gateway_mux.sv
hw/dbg_ring_router.sv
hw/dbg_host_ingress.sv
hw/dbg_host_egress.sv
hw/dbg_ring.sv
tb/dbg_ring_tb.sv
